/* fpsqrt_r4.f */
logic/fpsqrt_pkg.sv
logic/fpsqrt_unpack.sv
logic/fpsqrt_ctrl.sv
logic/fpsqrt_iter.sv
logic/fpsqrt_round.sv
logic/fpsqrt_top.sv
tests/fpsqrt_assertions.sv
tests/fpsqrt_checker.sv
tests/fpsqrt_tb.sv

/* logic/fpsqrt_ctrl.sv */
`timescale 1ns/1ns

module fpsqrt_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start_valid_i,
	input  fpsqrt_pkg::fmt_e fmt_i,
	input  logic             special_i,
	input  logic             flush_i,
	input  logic             finish_ready_i,
	output logic             start_ready_o,
	output logic             finish_valid_o,
	output logic             accept_o,
	output logic             step_o
);

	import fpsqrt_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ITER,
		DONE
	} state_e;

	state_e     state_q;
	state_e     state_d;
	logic [3:0] cnt_q;
	logic       last_iter;

	assign start_ready_o  = (state_q == IDLE);
	assign finish_valid_o = (state_q == DONE);
	assign step_o         = (state_q == ITER);
	assign accept_o       = start_valid_i & start_ready_o;

	// Counter holds the steps still to go, including the current one
	assign last_iter = (cnt_q == 4'd1);

	// ==================================================
	// FSM
	// ==================================================
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (accept_o) begin
					// Special operands skip the recurrence
					state_d = special_i ? DONE : ITER;
				end
			end
			ITER: begin
				if (last_iter) begin
					state_d = DONE;
				end
			end
			DONE: begin
				if (finish_ready_i) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
		// Flush wins over everything
		if (flush_i) begin
			state_d = IDLE;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			cnt_q   <= 4'd0;
		end else begin
			state_q <= state_d;
			if (accept_o) begin
				cnt_q <= (fmt_i == FMT_F16) ? F16_ITERS : F32_ITERS;
			end else if (step_o) begin
				cnt_q <= cnt_q - 4'd1;
			end
		end
	end

endmodule

/* logic/fpsqrt_iter.sv */
`timescale 1ns/1ns

module fpsqrt_iter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  load_i,
	input  logic                  step_i,
	input  fpsqrt_pkg::radicand_t radicand_i,
	output fpsqrt_pkg::root_t     root_o,
	output fpsqrt_pkg::rem_t      rem_o
);

	import fpsqrt_pkg::*;

	radicand_t rad_q;
	root_t     root_q;
	rem_t      rem_q;

	// Result of the first decision in a cycle
	root_t root_a;
	rem_t  rem_a;
	// Result of the second decision, loaded into the registers
	root_t root_b;
	rem_t  rem_b;

	// ==================================================
	// One restoring square-root bit
	// ==================================================
	// Brings down a pair, trial-subtracts 4*root + 1 and
	// appends the new root bit
	// Returns {next root, next remainder}
	function automatic logic [53:0] sqrt_bit(
		input root_t      root,
		input rem_t       rem,
		input logic [1:0] pair
	);
		rem_t        cur;
		logic [28:0] diff;
		logic        ge;
		// Upper remainder bits are zero here, remainder stays below 2 * root
		cur  = {rem[25:0], pair};
		diff = {1'b0, cur} - {1'b0, root, 2'b01};
		// No borrow means the trial value fits
		ge   = ~diff[28];
		return {root[24:0], ge, (ge ? diff[27:0] : cur)};
	endfunction

	// Two decisions in series per clock
	always_comb begin
		{root_a, rem_a} = sqrt_bit(root_q, rem_q, rad_q[51:50]);
		{root_b, rem_b} = sqrt_bit(root_a, rem_a, rad_q[49:48]);
	end

	// ==================================================
	// State registers
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rad_q  <= '0;
			root_q <= '0;
			rem_q  <= '0;
		end else if (load_i) begin
			rad_q  <= radicand_i;
			root_q <= '0;
			rem_q  <= '0;
		end else if (step_i) begin
			// Four radicand bits used per step
			rad_q  <= {rad_q[47:0], 4'b0000};
			root_q <= root_b;
			rem_q  <= rem_b;
		end
	end

	// binary32 takes 13 steps for 26 bits
	// binary16 stops after 6 and leaves its 12 bits at the bottom
	assign root_o = root_q;
	assign rem_o  = rem_q;

endmodule

/* logic/fpsqrt_pkg.sv */
package fpsqrt_pkg;

	// ==================================================
	// Word and field types
	// ==================================================

	// Operand and result word, binary16 lives in the low half
	typedef logic [31:0] fp_word_t;

	// Operand format select
	typedef enum logic {
		FMT_F16 = 1'b0,
		FMT_F32 = 1'b1
	} fmt_e;

	// Rounding mode code
	typedef logic [2:0] rm_t;

	// Biased result exponent, top bit takes the rounding carry
	typedef logic [8:0] exp_t;

	// Partial root, bit 25 is the integer bit once binary32 has finished
	// binary16 ends up in bits 11:0 and is left-aligned before rounding
	typedef logic [25:0] root_t;

	// Non-negative partial remainder
	typedef logic [27:0] rem_t;

	// Radicand as a stream of bit pairs, consumed from the top
	typedef logic [51:0] radicand_t;

	// Operand class, decides early finish and the special result
	typedef struct packed {
		logic is_nan;
		logic is_inf;
		logic is_zero;
		logic invalid;
	} op_class_t;

	// Everything the back end needs about the accepted operation
	typedef struct packed {
		logic      sign;
		fmt_e      fmt;
		rm_t       rm;
		exp_t      res_exp;
		op_class_t cls;
	} op_info_t;

	// ==================================================
	// Constants
	// ==================================================

	// Rounding modes, 5 to 7 fall back to truncation
	localparam rm_t RM_RNE = 3'd0;
	localparam rm_t RM_RTZ = 3'd1;
	localparam rm_t RM_RDN = 3'd2;
	localparam rm_t RM_RUP = 3'd3;
	localparam rm_t RM_RMM = 3'd4;

	localparam exp_t F16_BIAS = 9'd15;
	localparam exp_t F32_BIAS = 9'd127;

	// Two root bits per cycle, 12 bits for binary16 and 26 for binary32
	localparam logic [3:0] F16_ITERS = 4'd6;
	localparam logic [3:0] F32_ITERS = 4'd13;

	// Canonical quiet NaN patterns
	localparam logic [15:0] F16_QNAN = 16'h7E00;
	localparam fp_word_t    F32_QNAN = 32'h7FC0_0000;

endpackage

/* logic/fpsqrt_round.sv */
`timescale 1ns/1ns

module fpsqrt_round (
	input  fpsqrt_pkg::root_t    root_i,
	input  fpsqrt_pkg::rem_t     rem_i,
	input  fpsqrt_pkg::op_info_t info_i,
	output fpsqrt_pkg::fp_word_t res_o,
	output logic [4:0]           fflags_o
);

	import fpsqrt_pkg::*;

	logic        is_f16;
	logic        special;
	root_t       root_al;
	logic [22:0] frac_trunc;
	logic [23:0] inc_unit;
	logic [23:0] frac_sum;
	logic        round_bit;
	logic        sticky_bit;
	logic        round_up;
	logic        carry;
	exp_t        exp_rnd;
	logic [22:0] frac_rnd;
	logic [15:0] f16_res;
	fp_word_t    f32_res;

	assign is_f16  = (info_i.fmt == FMT_F16);
	assign special = info_i.cls.is_nan | info_i.cls.is_inf | info_i.cls.is_zero;

	// ==================================================
	// Alignment and round/sticky
	// ==================================================

	// Left-align the binary16 root so both formats share bit positions
	// binary32: [25] int, [24:2] fraction, [1] round, [0] extra
	// binary16: [25] int, [24:15] fraction, [14] round
	assign root_al = is_f16 ? {root_i[11:0], 14'b0} : root_i;

	assign frac_trunc = is_f16 ? {root_al[24:15], 13'b0} : root_al[24:2];
	assign round_bit  = is_f16 ? root_al[14] : root_al[1];
	// binary16 has no root bits below round
	assign sticky_bit = (rem_i != '0) | (~is_f16 & root_al[0]);

	// Result is never negative, so RDN behaves as RTZ
	// No exact midpoint exists for sqrt, RNE needs only the round bit
	always_comb begin
		case (info_i.rm)
			RM_RNE, RM_RMM: round_up = round_bit;
			RM_RUP:         round_up = round_bit | sticky_bit;
			RM_RTZ, RM_RDN: round_up = 1'b0;
			default:        round_up = 1'b0;
		endcase
	end

	// Increment at the format's LSB
	assign inc_unit = is_f16 ? 24'h00_2000 : 24'h00_0001;
	assign frac_sum = {1'b0, frac_trunc} + (round_up ? inc_unit : 24'h0);

	// Carry out leaves a zero fraction and bumps the exponent
	assign carry    = frac_sum[23];
	assign frac_rnd = frac_sum[22:0];
	assign exp_rnd  = info_i.res_exp + exp_t'(carry);

	// ==================================================
	// Result packing
	// ==================================================
	always_comb begin
		f32_res = {1'b0, exp_rnd[7:0], frac_rnd};
		f16_res = {1'b0, exp_rnd[4:0], frac_rnd[22:13]};
		if (info_i.cls.is_nan) begin
			f32_res = F32_QNAN;
			f16_res = F16_QNAN;
		end else if (info_i.cls.is_inf) begin
			f32_res = 32'h7F80_0000;
			f16_res = 16'h7C00;
		end else if (info_i.cls.is_zero) begin
			// sqrt(-0) is -0
			f32_res = {info_i.sign, 31'b0};
			f16_res = {info_i.sign, 15'b0};
		end
	end

	// binary16 zero-extended in the upper half
	assign res_o = is_f16 ? {16'h0000, f16_res} : f32_res;

	// Flags: invalid, divide-by-zero, overflow, underflow, inexact
	// Datapath is stale for special operands, so inexact is masked
	assign fflags_o = {
		info_i.cls.invalid,
		1'b0,
		1'b0,
		1'b0,
		(round_bit | sticky_bit) & ~special
	};

endmodule

/* logic/fpsqrt_top.sv */
`timescale 1ns/1ns

module fpsqrt_top (
	input  logic                 clk,
	input  logic                 rst_n,
	// Start handshake and operand
	input  logic                 start_valid_i,
	output logic                 start_ready_o,
	input  fpsqrt_pkg::fmt_e     fp_format_i,
	input  fpsqrt_pkg::fp_word_t op_i,
	input  fpsqrt_pkg::rm_t      rm_i,
	// Returns the unit to idle
	input  logic                 flush_i,
	// Finish handshake and result
	output logic                 finish_valid_o,
	input  logic                 finish_ready_i,
	output fpsqrt_pkg::fp_word_t fpsqrt_res_o,
	output logic [4:0]           fflags_o
);

	import fpsqrt_pkg::*;

	logic      accept;
	logic      special;
	logic      step;
	radicand_t radicand;
	root_t     root;
	rem_t      rem;
	op_info_t  info;

	// ==================================================
	// Front end and control
	// ==================================================

	// Classify the live operand and capture it on acceptance
	fpsqrt_unpack u_unpack (
		.clk        (clk),
		.rst_n      (rst_n),
		.op_i       (op_i),
		.fmt_i      (fp_format_i),
		.rm_i       (rm_i),
		.accept_i   (accept),
		.special_o  (special),
		.radicand_o (radicand),
		.info_o     (info)
	);

	fpsqrt_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid_i),
		.fmt_i          (fp_format_i),
		.special_i      (special),
		.flush_i        (flush_i),
		.finish_ready_i (finish_ready_i),
		.start_ready_o  (start_ready_o),
		.finish_valid_o (finish_valid_o),
		.accept_o       (accept),
		.step_o         (step)
	);

	// ==================================================
	// Recurrence and rounding
	// ==================================================

	fpsqrt_iter u_iter (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_i     (accept),
		.step_i     (step),
		.radicand_i (radicand),
		.root_o     (root),
		.rem_o      (rem)
	);

	// Combinational, result is valid whenever finish_valid_o is high
	fpsqrt_round u_round (
		.root_i   (root),
		.rem_i    (rem),
		.info_i   (info),
		.res_o    (fpsqrt_res_o),
		.fflags_o (fflags_o)
	);

endmodule

/* logic/fpsqrt_unpack.sv */
`timescale 1ns/1ns

module fpsqrt_unpack (
	input  logic                   clk,
	input  logic                   rst_n,
	input  fpsqrt_pkg::fp_word_t   op_i,
	input  fpsqrt_pkg::fmt_e       fmt_i,
	input  fpsqrt_pkg::rm_t        rm_i,
	input  logic                   accept_i,
	output logic                   special_o,
	output fpsqrt_pkg::radicand_t  radicand_o,
	output fpsqrt_pkg::op_info_t   info_o
);

	import fpsqrt_pkg::*;

	logic      is_f16;
	logic      sign;
	logic [7:0] exp_fld;
	logic [22:0] frac_fld;
	logic      exp_zero;
	logic      exp_max;
	logic      frac_zero;
	logic      is_nan;
	logic      is_snan;
	logic      exp_odd;
	exp_t      exp_sum;
	op_class_t cls;
	op_info_t  info_d;
	op_info_t  info_q;

	// ==================================================
	// Field extraction
	// ==================================================

	assign is_f16 = (fmt_i == FMT_F16);
	assign sign   = is_f16 ? op_i[15] : op_i[31];
	assign exp_fld = is_f16 ? {3'b000, op_i[14:10]} : op_i[30:23];
	// Fraction MSB aligned for both formats, so bit 22 is the quiet bit
	assign frac_fld = is_f16 ? {op_i[9:0], 13'b0} : op_i[22:0];

	assign exp_zero  = (exp_fld == 8'd0);
	assign exp_max   = is_f16 ? (op_i[14:10] == 5'h1F) : (op_i[30:23] == 8'hFF);
	assign frac_zero = (frac_fld == 23'd0);
	assign is_nan    = exp_max & ~frac_zero;
	assign is_snan   = is_nan & ~frac_fld[22];

	// Classification
	// Subnormals are flushed, so a zero exponent field is a zero
	assign cls.is_zero = exp_zero;
	assign cls.invalid = is_snan | (sign & ~exp_zero & ~is_nan);
	// Invalid operations also give the quiet NaN
	assign cls.is_nan  = is_nan | cls.invalid;
	assign cls.is_inf  = exp_max & frac_zero & ~sign;

	assign special_o = cls.is_nan | cls.is_inf | cls.is_zero;

	// Result exponent is bias + floor(e/2) = floor((E + bias) / 2)
	assign exp_sum = exp_t'(exp_fld) + (is_f16 ? F16_BIAS : F32_BIAS);
	// Bias is odd, so an even field means an odd unbiased exponent
	assign exp_odd = ~exp_fld[0];

	// Two integer bits in front, odd exponents use twice the significand
	assign radicand_o = exp_odd ? {1'b1, frac_fld, 28'b0} : {2'b01, frac_fld, 27'b0};

	assign info_d.sign    = sign;
	assign info_d.fmt     = fmt_i;
	assign info_d.rm      = rm_i;
	assign info_d.res_exp = {1'b0, exp_sum[8:1]};
	assign info_d.cls     = cls;

	// Operation info, held until the next acceptance
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			info_q <= '0;
		end else if (accept_i) begin
			info_q <= info_d;
		end
	end

	assign info_o = info_q;

endmodule

/* tests/fpsqrt_assertions.sv */
`timescale 1ns/1ns

module fpsqrt_assertions (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 start_ready_i,
	input logic                 finish_valid_i,
	input logic                 finish_ready_i,
	input logic                 flush_i,
	input fpsqrt_pkg::fp_word_t res_i,
	input logic [4:0]           fflags_i
);

	// Assertion failures so far
	int fail_cnt = 0;

	// ==================================================
	// Handshake properties
	// ==================================================

	// Unit is either waiting for work or holding a result
	ready_valid_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(start_ready_i && finish_valid_i))
		else begin
			$error("start_ready_o and finish_valid_o high together");
			fail_cnt++;
		end

	// Result waits unchanged for the consumer
	result_held: assert property (@(posedge clk) disable iff (!rst_n)
		finish_valid_i && !finish_ready_i && !flush_i |=>
		finish_valid_i && $stable(res_i) && $stable(fflags_i))
		else begin
			$error("result not held while finish_ready_i low");
			fail_cnt++;
		end

	// Divide-by-zero, overflow and underflow cannot occur in sqrt
	unused_flags_zero: assert property (@(posedge clk) disable iff (!rst_n)
		fflags_i[3:1] == 3'b000)
		else begin
			$error("DZ, OF or UF flag set");
			fail_cnt++;
		end

endmodule

bind fpsqrt_top fpsqrt_assertions u_assertions (
	.clk            (clk),
	.rst_n          (rst_n),
	.start_ready_i  (start_ready_o),
	.finish_valid_i (finish_valid_o),
	.finish_ready_i (finish_ready_i),
	.flush_i        (flush_i),
	.res_i          (fpsqrt_res_o),
	.fflags_i       (fflags_o)
);

/* tests/fpsqrt_checker.sv */
`timescale 1ns/1ns

module fpsqrt_checker (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start_valid_i,
	input  logic                 start_ready_i,
	input  fpsqrt_pkg::fmt_e     fmt_i,
	input  fpsqrt_pkg::fp_word_t op_i,
	input  fpsqrt_pkg::rm_t      rm_i,
	input  logic                 flush_i,
	input  logic                 finish_valid_i,
	input  logic                 finish_ready_i,
	input  fpsqrt_pkg::fp_word_t res_i,
	input  logic [4:0]           fflags_i,
	output int                   err_cnt_o,
	output int                   cmp_cnt_o
);

	import fpsqrt_pkg::*;

	logic       pending;
	fp_word_t   cur_op;
	fp_word_t   exp_res;
	logic [4:0] exp_flags;

	// ==================================================
	// Reference square root, returns {flags, result}
	// ==================================================
	// Subnormal operands count as zero, flags are NV,DZ,OF,UF,NX
	function automatic logic [36:0] sqrt_ref(
		input fp_word_t op,
		input logic     is_f16,
		input rm_t      rm
	);
		int          fbits;
		int          ebits;
		int          bias;
		int          emax;
		int          efld;
		int          e;
		int          eres;
		logic        sign;
		logic        odd;
		logic        nv;
		logic        nx;
		logic        rnd;
		logic        stk;
		logic        up;
		logic [31:0] frac;
		logic [63:0] x;
		logic [63:0] lo;
		logic [63:0] hi;
		logic [63:0] mid;
		logic [63:0] q;
		fp_word_t    res;
		fbits = is_f16 ? 10 : 23;
		ebits = is_f16 ? 5 : 8;
		bias  = is_f16 ? 15 : 127;
		emax  = (1 << ebits) - 1;
		sign  = op[ebits + fbits];
		efld  = int'((op >> fbits) & ((32'd1 << ebits) - 1));
		frac  = op & ((32'd1 << fbits) - 1);
		nv    = 1'b0;
		nx    = 1'b0;
		if (efld == emax && frac != 0) begin
			// Any NaN gives the canonical one, signalling raises invalid
			res = is_f16 ? 32'h0000_7E00 : 32'h7FC0_0000;
			nv  = ~frac[fbits - 1];
		end else if (efld == 0) begin
			res = fp_word_t'(sign) << (ebits + fbits);
		end else if (sign) begin
			res = is_f16 ? 32'h0000_7E00 : 32'h7FC0_0000;
			nv  = 1'b1;
		end else if (efld == emax) begin
			res = is_f16 ? 32'h0000_7C00 : 32'h7F80_0000;
		end else begin
			e   = efld - bias;
			odd = e[0];
			// Significand in [1,4) scaled by 2^52
			x   = (64'd1 << fbits) | 64'(frac);
			x   = (x << odd) << (52 - fbits);
			// Integer sqrt by bisection, root below 2^27
			lo  = 64'd0;
			hi  = 64'd1 << 27;
			while (hi - lo > 1) begin
				mid = (lo + hi) >> 1;
				if (mid * mid <= x) lo = mid;
				else hi = mid;
			end
			// Root has its integer bit at 26
			q   = lo >> (26 - fbits);
			rnd = lo[25 - fbits];
			stk = ((lo & ((64'd1 << (25 - fbits)) - 1)) != 0) || (lo * lo != x);
			case (rm)
				RM_RNE, RM_RMM: up = rnd;
				RM_RUP:         up = rnd | stk;
				default:        up = 1'b0;
			endcase
			q    = q + 64'(up);
			eres = bias + (e - int'(odd)) / 2;
			// Significand overflow to 2.0
			if (q >> (fbits + 1) != 0) begin
				eres = eres + 1;
				q    = q >> 1;
			end
			res = (fp_word_t'(eres) << fbits) | fp_word_t'(q & ((64'd1 << fbits) - 1));
			nx  = rnd | stk;
		end
		return {nv, 3'b000, nx, res};
	endfunction

	// ==================================================
	// Compare at the falling edge, inputs and outputs settled
	// ==================================================
	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending   <= 1'b0;
			err_cnt_o <= 0;
			cmp_cnt_o <= 0;
		end else if (flush_i) begin
			// Flushed operation never delivers
			pending <= 1'b0;
		end else begin
			if (start_valid_i && start_ready_i) begin
				{exp_flags, exp_res} <= sqrt_ref(op_i, fmt_i == FMT_F16, rm_i);
				cur_op  <= op_i;
				pending <= 1'b1;
			end
			if (finish_valid_i && finish_ready_i) begin
				pending <= 1'b0;
				if (!pending) begin
					$display("ERR %0t: result delivered with no operation in flight", $time);
					err_cnt_o <= err_cnt_o + 1;
				end else begin
					cmp_cnt_o <= cmp_cnt_o + 1;
					if (res_i !== exp_res || fflags_i !== exp_flags) begin
						$display("ERR %0t: sqrt(%h) gave %h flags %b, expected %h flags %b",
							$time, cur_op, res_i, fflags_i, exp_res, exp_flags);
						err_cnt_o <= err_cnt_o + 1;
					end
				end
			end
		end
	end

endmodule

/* tests/fpsqrt_tb.sv */
`timescale 1ns/1ns

module fpsqrt_tb;

	import fpsqrt_pkg::*;

	// Upper bound on any wait, in cycles
	localparam int WAIT_LIMIT = 100;

	// Special operands: +0 -0 +inf -inf qNaN sNaN -4 +sub -sub
	localparam fp_word_t SPEC32 [9] = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000,
		32'hFF80_0000, 32'h7FC0_0000, 32'h7F80_0001, 32'hC080_0000, 32'h0040_0000,
		32'h8040_0000};
	localparam fp_word_t SPEC16 [9] = '{32'h0000, 32'h8000, 32'h7C00, 32'hFC00,
		32'h7E00, 32'h7C01, 32'hC400, 32'h0200, 32'h8200};
	// Exact squares 4.0 9.0 2.25 0.25
	localparam fp_word_t SQUARES [4] = '{32'h4080_0000, 32'h4110_0000,
		32'h4010_0000, 32'h3E80_0000};

	logic       clk;
	logic       rst_n;
	logic       start_valid;
	logic       start_ready;
	fmt_e       fmt;
	fp_word_t   op;
	rm_t        rm;
	logic       flush;
	logic       finish_valid;
	logic       finish_ready;
	fp_word_t   res;
	logic [4:0] fflags;
	int         chk_errs;
	int         chk_cmps;
	int         tb_errs;
	int         test_cnt;
	int         test_ops;
	int         total_ops;
	int         errs_before;
	int         k;
	int         j;
	fmt_e       f;

	fpsqrt_top dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid),
		.start_ready_o  (start_ready),
		.fp_format_i    (fmt),
		.op_i           (op),
		.rm_i           (rm),
		.flush_i        (flush),
		.finish_valid_o (finish_valid),
		.finish_ready_i (finish_ready),
		.fpsqrt_res_o   (res),
		.fflags_o       (fflags)
	);

	fpsqrt_checker chk (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid),
		.start_ready_i  (start_ready),
		.fmt_i          (fmt),
		.op_i           (op),
		.rm_i           (rm),
		.flush_i        (flush),
		.finish_valid_i (finish_valid),
		.finish_ready_i (finish_ready),
		.res_i          (res),
		.fflags_i       (fflags),
		.err_cnt_o      (chk_errs),
		.cmp_cnt_o      (chk_cmps)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==================================================
	// Helpers
	// ==================================================

	// Checker, testbench and assertion failures together
	function automatic int error_total();
		return chk_errs + tb_errs + dut.u_assertions.fail_cnt;
	endfunction

	// Random normal operand, binary16 in the low half
	function automatic fp_word_t rand_operand(input fmt_e ff);
		if (ff == FMT_F16) begin
			return {16'h0000, 1'b0, 5'($urandom_range(30, 1)), 10'($urandom)};
		end
		return {1'b0, 8'($urandom_range(254, 1)), 23'($urandom)};
	endfunction

	// N iteration cycles plus DONE
	function automatic int normal_latency(input fmt_e ff);
		return (ff == FMT_F16) ? 7 : 14;
	endfunction

	// Inputs change 1 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$finish;
	endtask

	task automatic wait_start_ready();
		int n;
		n = 0;
		while (!start_ready) begin
			step_cycle();
			n++;
			if (n > WAIT_LIMIT) abort_run("Timeout: the unit never raised start_ready_o");
		end
	endtask

	// One operation, latency checked, result held for hold cycles
	task automatic run_op(input fp_word_t a, input fmt_e ff, input rm_t m,
		input int latency, input int hold);
		int         n;
		fp_word_t   held_res;
		logic [4:0] held_flags;
		wait_start_ready();
		op          = a;
		fmt         = ff;
		rm          = m;
		start_valid = 1'b1;
		// Acceptance edge
		step_cycle();
		start_valid = 1'b0;
		n = 1;
		while (!finish_valid) begin
			step_cycle();
			n++;
			if (n > WAIT_LIMIT) abort_run("Timeout: the unit never raised finish_valid_o");
		end
		if (n != latency) begin
			$display("ERR %0t: latency %0d cycles, expected %0d for %h", $time, n, latency, a);
			tb_errs++;
		end
		held_res   = res;
		held_flags = fflags;
		for (n = 0; n < hold; n++) begin
			step_cycle();
			if (!finish_valid || res !== held_res || fflags !== held_flags) begin
				$display("ERR %0t: result changed under back-pressure", $time);
				tb_errs++;
			end
		end
		finish_ready = 1'b1;
		step_cycle();
		finish_ready = 1'b0;
		if (!start_ready) begin
			$display("start_ready_o did not return after the result was taken");
			tb_errs++;
		end
		test_ops++;
		total_ops++;
	endtask

	// Accept, flush during ITER, then watch for a stray result
	task automatic flush_op(input fp_word_t a, input fmt_e ff, input int delay);
		int   n;
		logic seen;
		wait_start_ready();
		op          = a;
		fmt         = ff;
		start_valid = 1'b1;
		step_cycle();
		start_valid = 1'b0;
		for (n = 0; n < delay; n++) begin
			step_cycle();
		end
		flush = 1'b1;
		step_cycle();
		flush = 1'b0;
		seen  = 1'b0;
		for (n = 0; n < 20; n++) begin
			seen = seen | finish_valid;
			step_cycle();
		end
		if (seen) begin
			$display("finish_valid_o rose for a flushed operation");
			tb_errs++;
		end
	endtask

	task automatic begin_test();
		errs_before = error_total();
		test_ops    = 0;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		$display("Test %s: %0d operations, %0d errors", name, test_ops,
			error_total() - errs_before);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		void'($urandom(32'h6221_bab6));
		rst_n        = 1'b0;
		start_valid  = 1'b0;
		fmt          = FMT_F32;
		op           = '0;
		rm           = RM_RNE;
		flush        = 1'b0;
		finish_ready = 1'b0;
		tb_errs      = 0;
		test_cnt     = 0;
		total_ops    = 0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		step_cycle();

		begin_test();
		for (k = 0; k < 9; k++) begin
			run_op(SPEC32[k], FMT_F32, rm_t'($urandom_range(4, 0)), 1, 0);
			run_op(SPEC16[k], FMT_F16, rm_t'($urandom_range(4, 0)), 1, 0);
		end
		end_test("special values");

		begin_test();
		for (k = 0; k < 4; k++) begin
			for (j = 0; j < 5; j++) begin
				run_op(SQUARES[k], FMT_F32, rm_t'(j), 14, 0);
			end
		end
		for (k = 0; k < 300; k++) begin
			run_op(rand_operand(FMT_F32), FMT_F32, rm_t'($urandom_range(4, 0)), 14, 0);
		end
		end_test("binary32 normals");

		begin_test();
		// All-ones fraction, odd exponent, carries into the exponent under RUP
		for (j = 0; j < 5; j++) begin
			run_op(32'h0000_43FF, FMT_F16, rm_t'(j), 7, 0);
		end
		for (k = 0; k < 200; k++) begin
			run_op(rand_operand(FMT_F16), FMT_F16, rm_t'($urandom_range(4, 0)), 7, 0);
		end
		end_test("binary16 normals");

		begin_test();
		for (k = 0; k < 10; k++) begin
			f = fmt_e'(k[0]);
			run_op(rand_operand(f), f, RM_RNE, normal_latency(f), 0);
		end
		end_test("fixed latency");

		begin_test();
		for (k = 0; k < 40; k++) begin
			f = fmt_e'($urandom_range(1, 0));
			run_op(rand_operand(f), f, rm_t'($urandom_range(4, 0)), normal_latency(f),
				$urandom_range(10, 0));
		end
		end_test("back-pressure");

		begin_test();
		for (k = 0; k < 4; k++) begin
			f = fmt_e'(k[0]);
			flush_op(rand_operand(f), f, $urandom_range(4, 0));
			run_op(rand_operand(f), f, rm_t'($urandom_range(4, 0)), normal_latency(f), 0);
		end
		end_test("flush");

		$display("Summary: %0d tests, %0d operations, %0d compared, %0d errors",
			test_cnt, total_ops, chk_cmps, error_total());
		if (error_total() == 0 && chk_cmps == total_ops) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
